/* armIsaPkg.sv */
`default_nettype none

package armIsaPkg;

    // register index, r15 is the program counter
    typedef logic [3:0] regIdxT;

    // condition field, instr[31:28]
    typedef enum logic [3:0] {
        EQ = 4'b0000,
        NE = 4'b0001,
        CS = 4'b0010,
        CC = 4'b0011,
        MI = 4'b0100,
        PL = 4'b0101,
        VS = 4'b0110,
        VC = 4'b0111,
        HI = 4'b1000,
        LS = 4'b1001,
        GE = 4'b1010,
        LT = 4'b1011,
        GT = 4'b1100,
        LE = 4'b1101,
        AL = 4'b1110
    } condT;

    // data-processing cmd field, instr[24:21]
    typedef enum logic [3:0] {
        dpAnd = 4'b0000,
        dpSub = 4'b0010,
        dpAdd = 4'b0100,
        dpCmp = 4'b1010,
        dpOrr = 4'b1100
    } dpOpT;

    // op field, instr[27:26]
    typedef enum logic [1:0] {
        classDp     = 2'b00,
        classMem    = 2'b01,
        classBranch = 2'b10
    } instrClassT;

    localparam regIdxT pcRegIdx = 4'd15;

endpackage

`default_nettype wire

/* armPipePkg.sv */
`default_nettype none

package armPipePkg;

    typedef logic [31:0] wordT;

    typedef enum logic [1:0] {
        aluAdd = 2'b00,
        aluSub = 2'b01,
        aluAnd = 2'b10,
        aluOr  = 2'b11
    } aluCtrlT;

    // execute operand source
    typedef enum logic [1:0] {
        fwdReg = 2'b00,
        fwdWb  = 2'b01,
        fwdMem = 2'b10
    } fwdSelT;

    // N Z C V, msb first
    typedef logic [3:0] flagsT;

    localparam wordT resetPc = 32'h0000_0000;
    localparam wordT pcStep = 32'd4;

endpackage

`default_nettype wire

/* armDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module armDecoder (
    input  wire armPipePkg::wordT    instr,
    output armIsaPkg::condT          cond,
    output armPipePkg::aluCtrlT      aluCtrl,
    output logic                     regWrite,
    output logic                     memWrite,
    output logic                     memToReg,
    output logic                     aluSrcImm,
    output logic                     isBranch,
    output logic                     flagWrite,
    output logic                     noWrite,
    output armIsaPkg::regIdxT        ra1,
    output armIsaPkg::regIdxT        ra2,
    output armIsaPkg::regIdxT        wa3,
    output armPipePkg::wordT         extImm
);

    armIsaPkg::instrClassT instrClass;
    armIsaPkg::dpOpT dpOp;
    logic isLoad;

    assign cond = armIsaPkg::condT'(instr[31:28]);
    assign instrClass = armIsaPkg::instrClassT'(instr[27:26]);
    assign dpOp = armIsaPkg::dpOpT'(instr[24:21]);
    // L bit for memory, S bit for data processing
    assign isLoad = instr[20];

    always_comb begin
        aluCtrl = armPipePkg::aluAdd;
        regWrite = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        aluSrcImm = 1'b0;
        isBranch = 1'b0;
        flagWrite = 1'b0;
        noWrite = 1'b0;
        ra1 = instr[19:16];
        ra2 = instr[3:0];
        wa3 = instr[15:12];
        extImm = {24'b0, instr[7:0]};
        case (instrClass)
            armIsaPkg::classDp: begin
                aluSrcImm = instr[25];
                flagWrite = instr[20];
                regWrite = 1'b1;
                case (dpOp)
                    armIsaPkg::dpAnd: aluCtrl = armPipePkg::aluAnd;
                    armIsaPkg::dpSub: aluCtrl = armPipePkg::aluSub;
                    armIsaPkg::dpAdd: aluCtrl = armPipePkg::aluAdd;
                    armIsaPkg::dpOrr: aluCtrl = armPipePkg::aluOr;
                    armIsaPkg::dpCmp: begin
                        aluCtrl = armPipePkg::aluSub;
                        noWrite = 1'b1;
                        flagWrite = 1'b1;
                    end
                    default: begin
                        regWrite = 1'b0;
                        flagWrite = 1'b0;
                    end
                endcase
            end
            armIsaPkg::classMem: begin
                aluSrcImm = 1'b1;
                extImm = {20'b0, instr[11:0]};
                // U bit picks offset direction
                aluCtrl = instr[23] ? armPipePkg::aluAdd : armPipePkg::aluSub;
                regWrite = isLoad;
                memToReg = isLoad;
                memWrite = ~isLoad;
                // store data comes from Rd
                ra2 = instr[15:12];
            end
            armIsaPkg::classBranch: begin
                aluSrcImm = 1'b1;
                isBranch = 1'b1;
                ra1 = armIsaPkg::pcRegIdx;
                extImm = {{6{instr[23]}}, instr[23:0], 2'b00};
            end
            default: begin
                regWrite = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* armRegFile.sv */
`timescale 1ns/1ps
`default_nettype none

module armRegFile (
    input  wire                      CLK,
    input  wire                      we,
    input  wire armIsaPkg::regIdxT   wa,
    input  wire armPipePkg::wordT    wd,
    input  wire armIsaPkg::regIdxT   ra1,
    input  wire armIsaPkg::regIdxT   ra2,
    input  wire armPipePkg::wordT    pcPlus8,
    output armPipePkg::wordT         rd1,
    output armPipePkg::wordT         rd2
);

    // r0 to r14, r15 lives in the fetch stage
    armPipePkg::wordT regs [0:14];

    // falling edge write so decode sees the value in the same cycle
    always_ff @(negedge CLK) begin
        if (we && wa != armIsaPkg::pcRegIdx) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == armIsaPkg::pcRegIdx) ? pcPlus8 : regs[ra1];
    assign rd2 = (ra2 == armIsaPkg::pcRegIdx) ? pcPlus8 : regs[ra2];

endmodule

`default_nettype wire

/* armExecute.sv */
`timescale 1ns/1ps
`default_nettype none

module armExecute (
    input  wire                        CLK,
    input  wire                        Reset,
    input  wire                        hold,
    input  wire armPipePkg::wordT      srcA,
    input  wire armPipePkg::wordT      srcB,
    input  wire armPipePkg::aluCtrlT   aluCtrl,
    input  wire armIsaPkg::condT       cond,
    input  wire                        regWriteIn,
    input  wire                        memWriteIn,
    input  wire                        isBranchIn,
    input  wire                        flagWriteIn,
    input  wire                        noWriteIn,
    output armPipePkg::wordT           aluResult,
    output logic                       regWrite,
    output logic                       memWrite,
    output logic                       branchTaken
);

    armPipePkg::flagsT flags;
    armPipePkg::flagsT aluFlags;
    logic [32:0] sum;
    logic isSub;
    logic isArith;
    logic condPass;
    logic n, z, c, v;

    assign isSub = (aluCtrl == armPipePkg::aluSub);
    assign isArith = isSub || (aluCtrl == armPipePkg::aluAdd);
    // subtract as a + ~b + 1, carry out is not-borrow
    assign sum = {1'b0, srcA} + {1'b0, isSub ? ~srcB : srcB} + {32'b0, isSub};

    always_comb begin
        case (aluCtrl)
            armPipePkg::aluAnd: aluResult = srcA & srcB;
            armPipePkg::aluOr:  aluResult = srcA | srcB;
            default:            aluResult = sum[31:0];
        endcase
    end

    assign aluFlags[3] = aluResult[31];
    assign aluFlags[2] = (aluResult == '0);
    // logical ops leave C and V alone
    assign aluFlags[1] = isArith ? sum[32] : flags[1];
    assign aluFlags[0] = isArith ? (~(srcA[31] ^ srcB[31] ^ isSub) & (srcA[31] ^ sum[31]))
                                 : flags[0];

    assign {n, z, c, v} = flags;

    always_comb begin
        case (cond)
            armIsaPkg::EQ: condPass = z;
            armIsaPkg::NE: condPass = ~z;
            armIsaPkg::CS: condPass = c;
            armIsaPkg::CC: condPass = ~c;
            armIsaPkg::MI: condPass = n;
            armIsaPkg::PL: condPass = ~n;
            armIsaPkg::VS: condPass = v;
            armIsaPkg::VC: condPass = ~v;
            armIsaPkg::HI: condPass = c & ~z;
            armIsaPkg::LS: condPass = ~c | z;
            armIsaPkg::GE: condPass = (n == v);
            armIsaPkg::LT: condPass = (n != v);
            armIsaPkg::GT: condPass = ~z & (n == v);
            armIsaPkg::LE: condPass = z | (n != v);
            armIsaPkg::AL: condPass = 1'b1;
            default:       condPass = 1'b0;
        endcase
    end

    // no update while held, the instruction stays in execute
    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            flags <= '0;
        end else if (flagWriteIn && condPass && !hold) begin
            flags <= aluFlags;
        end
    end

    assign regWrite = regWriteIn & condPass & ~noWriteIn;
    assign memWrite = memWriteIn & condPass;
    assign branchTaken = isBranchIn & condPass;

endmodule

`default_nettype wire

/* armHazard.sv */
`timescale 1ns/1ps
`default_nettype none

module armHazard (
    input  wire armIsaPkg::regIdxT   ra1E,
    input  wire armIsaPkg::regIdxT   ra2E,
    input  wire armIsaPkg::regIdxT   wa3M,
    input  wire armIsaPkg::regIdxT   wa3W,
    input  wire armIsaPkg::regIdxT   ra1D,
    input  wire armIsaPkg::regIdxT   ra2D,
    input  wire armIsaPkg::regIdxT   wa3E,
    input  wire                      regWriteM,
    input  wire                      regWriteW,
    input  wire                      memToRegE,
    input  wire                      cpuValidM,
    input  wire                      cacheReady,
    input  wire                      branchTaken,
    output armPipePkg::fwdSelT       fwdA,
    output armPipePkg::fwdSelT       fwdB,
    output logic                     stallF,
    output logic                     stallD,
    output logic                     stallM,
    output logic                     flushD,
    output logic                     flushE
);

    logic ldStall;
    logic memStall;

    // memory stage wins over writeback, r15 always from the register file
    function automatic armPipePkg::fwdSelT pickSrc(
        armIsaPkg::regIdxT ra, armIsaPkg::regIdxT waM, armIsaPkg::regIdxT waW,
        logic weM, logic weW
    );
        if (ra == armIsaPkg::pcRegIdx) begin
            pickSrc = armPipePkg::fwdReg;
        end else if (weM && waM == ra) begin
            pickSrc = armPipePkg::fwdMem;
        end else if (weW && waW == ra) begin
            pickSrc = armPipePkg::fwdWb;
        end else begin
            pickSrc = armPipePkg::fwdReg;
        end
    endfunction

    assign fwdA = pickSrc(ra1E, wa3M, wa3W, regWriteM, regWriteW);
    assign fwdB = pickSrc(ra2E, wa3M, wa3W, regWriteM, regWriteW);

    assign ldStall = memToRegE && (wa3E == ra1D || wa3E == ra2D);
    assign memStall = cpuValidM && !cacheReady;

    assign stallM = memStall;
    assign stallF = memStall | ldStall;
    assign stallD = memStall | ldStall;
    assign flushD = ~memStall & branchTaken;
    assign flushE = ~memStall & (ldStall | branchTaken);

endmodule

`default_nettype wire

/* armCore.sv */
`timescale 1ns/1ps
`default_nettype none

module armCore (
    input  wire                      CLK,
    input  wire                      Reset,
    input  wire armPipePkg::wordT    instr,
    input  wire armPipePkg::wordT    readData,
    input  wire                      cacheReady,
    output armPipePkg::wordT         pc,
    output armPipePkg::wordT         aluResult,
    output armPipePkg::wordT         writeData,
    output logic                     cpuValid,
    output logic                     cpuOp
);

    // decode stage
    armPipePkg::wordT instrD;
    logic validD;
    armIsaPkg::condT condD;
    armPipePkg::aluCtrlT aluCtrlD;
    logic regWriteD, memWriteD, memToRegD, aluSrcImmD, isBranchD, flagWriteD, noWriteD;
    armIsaPkg::regIdxT ra1D, ra2D, wa3D;
    armPipePkg::wordT extImmD, rd1D, rd2D;

    // execute stage
    armIsaPkg::condT condE;
    armPipePkg::aluCtrlT aluCtrlE;
    logic regWriteE, memWriteE, memToRegE, aluSrcImmE, isBranchE, flagWriteE, noWriteE;
    armIsaPkg::regIdxT ra1E, ra2E, wa3E;
    armPipePkg::wordT extImmE, rd1E, rd2E;
    armPipePkg::wordT srcAE, writeDataE, srcBE, aluResultE;
    logic regWriteQE, memWriteQE, branchTaken;

    // memory and writeback stages
    logic regWriteM, memWriteM, memToRegM;
    armIsaPkg::regIdxT wa3M, wa3W;
    armPipePkg::wordT aluResultM, writeDataM, aluResultW, readDataW, resultW;
    logic regWriteW, memToRegW;

    armPipePkg::fwdSelT fwdA, fwdB;
    logic stallF, stallD, stallM, flushD, flushE;

    function automatic armPipePkg::wordT fwdMux(
        armPipePkg::fwdSelT sel, armPipePkg::wordT regVal,
        armPipePkg::wordT memVal, armPipePkg::wordT wbVal
    );
        case (sel)
            armPipePkg::fwdMem: fwdMux = memVal;
            armPipePkg::fwdWb:  fwdMux = wbVal;
            default:            fwdMux = regVal;
        endcase
    endfunction

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            pc <= armPipePkg::resetPc;
        end else if (!stallF) begin
            pc <= branchTaken ? aluResultE : pc + armPipePkg::pcStep;
        end
    end

    // fetch to decode
    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            validD <= 1'b0;
        end else if (!stallD) begin
            validD <= ~flushD;
            instrD <= instr;
        end
    end

    armDecoder decoder (
        .instr(instrD), .cond(condD), .aluCtrl(aluCtrlD),
        .regWrite(regWriteD), .memWrite(memWriteD), .memToReg(memToRegD),
        .aluSrcImm(aluSrcImmD), .isBranch(isBranchD), .flagWrite(flagWriteD),
        .noWrite(noWriteD), .ra1(ra1D), .ra2(ra2D), .wa3(wa3D), .extImm(extImmD)
    );

    // decode instruction sits one word behind fetch, so its pc+8 is pc+4
    armRegFile regFile (
        .CLK(CLK), .we(regWriteW), .wa(wa3W), .wd(resultW),
        .ra1(ra1D), .ra2(ra2D), .pcPlus8(pc + armPipePkg::pcStep),
        .rd1(rd1D), .rd2(rd2D)
    );

    // decode to execute
    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            regWriteE <= 1'b0;
            memWriteE <= 1'b0;
            memToRegE <= 1'b0;
            isBranchE <= 1'b0;
            flagWriteE <= 1'b0;
        end else if (stallM) begin
            // held instruction keeps forwarded operands, writeback turns into a bubble
            rd1E <= srcAE;
            rd2E <= writeDataE;
        end else if (flushE || !validD) begin
            regWriteE <= 1'b0;
            memWriteE <= 1'b0;
            memToRegE <= 1'b0;
            isBranchE <= 1'b0;
            flagWriteE <= 1'b0;
        end else begin
            regWriteE <= regWriteD;
            memWriteE <= memWriteD;
            memToRegE <= memToRegD;
            isBranchE <= isBranchD;
            flagWriteE <= flagWriteD;
            condE <= condD;
            aluCtrlE <= aluCtrlD;
            aluSrcImmE <= aluSrcImmD;
            noWriteE <= noWriteD;
            ra1E <= ra1D;
            ra2E <= ra2D;
            wa3E <= wa3D;
            rd1E <= rd1D;
            rd2E <= rd2D;
            extImmE <= extImmD;
        end
    end

    assign srcAE = fwdMux(fwdA, rd1E, aluResultM, resultW);
    assign writeDataE = fwdMux(fwdB, rd2E, aluResultM, resultW);
    assign srcBE = aluSrcImmE ? extImmE : writeDataE;

    armExecute execute (
        .CLK(CLK), .Reset(Reset), .hold(stallM),
        .srcA(srcAE), .srcB(srcBE), .aluCtrl(aluCtrlE), .cond(condE),
        .regWriteIn(regWriteE), .memWriteIn(memWriteE), .isBranchIn(isBranchE),
        .flagWriteIn(flagWriteE), .noWriteIn(noWriteE),
        .aluResult(aluResultE), .regWrite(regWriteQE), .memWrite(memWriteQE),
        .branchTaken(branchTaken)
    );

    // execute to memory, a load only goes on when its condition passed
    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            regWriteM <= 1'b0;
            memWriteM <= 1'b0;
            memToRegM <= 1'b0;
        end else if (!stallM) begin
            regWriteM <= regWriteQE;
            memWriteM <= memWriteQE;
            memToRegM <= memToRegE & regWriteQE;
            aluResultM <= aluResultE;
            writeDataM <= writeDataE;
            wa3M <= wa3E;
        end
    end

    assign cpuValid = memWriteM | memToRegM;
    assign cpuOp = ~memWriteM;
    assign aluResult = aluResultM;
    assign writeData = writeDataM;

    // memory to writeback
    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            regWriteW <= 1'b0;
            memToRegW <= 1'b0;
        end else if (stallM) begin
            regWriteW <= 1'b0;
            memToRegW <= 1'b0;
        end else begin
            regWriteW <= regWriteM;
            memToRegW <= memToRegM;
            aluResultW <= aluResultM;
            readDataW <= readData;
            wa3W <= wa3M;
        end
    end

    assign resultW = memToRegW ? readDataW : aluResultW;

    armHazard hazard (
        .ra1E(ra1E), .ra2E(ra2E), .wa3M(wa3M), .wa3W(wa3W),
        .ra1D(ra1D), .ra2D(ra2D), .wa3E(wa3E),
        .regWriteM(regWriteM), .regWriteW(regWriteW), .memToRegE(memToRegE),
        .cpuValidM(cpuValid), .cacheReady(cacheReady), .branchTaken(branchTaken),
        .fwdA(fwdA), .fwdB(fwdB), .stallF(stallF), .stallD(stallD),
        .stallM(stallM), .flushD(flushD), .flushE(flushE)
    );

endmodule

`default_nettype wire

/* tbClock.sv */
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic CLK,
    output logic Reset
);

    // 4 ns period
    initial begin
        CLK = 1'b0;
        forever begin
            #2 CLK = ~CLK;
        end
    end

    // three rising edges in reset, released on a falling edge
    initial begin
        Reset = 1'b1;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        Reset = 1'b0;
    end

endmodule

`default_nettype wire

/* armCoreChk.sv */
`timescale 1ns/1ps
`default_nettype none

module armCoreChk (
    input wire                      CLK,
    input wire                      Reset,
    input wire armPipePkg::wordT    pc,
    input wire armPipePkg::wordT    aluResult,
    input wire armPipePkg::wordT    writeData,
    input wire                      cpuValid,
    input wire                      cpuOp,
    input wire                      cacheReady
);

    int failCount = 0;

    // a waiting access keeps address, direction and store data
    stableRequest: assert property (@(posedge CLK) disable iff (Reset)
        cpuValid && !cacheReady |=> cpuValid && $stable(aluResult) && $stable(cpuOp)
            && (cpuOp || $stable(writeData)))
    else begin
        $error("cache request changed before the cache answered");
        failCount++;
    end

    noAccessInReset: assert property (@(posedge CLK) Reset |-> !cpuValid)
    else begin
        $error("cpuValid high while in reset");
        failCount++;
    end

    // first cycles out of reset fetch from the reset address, no access yet
    cleanStart: assert property (@(posedge CLK)
        $fell(Reset) |-> (pc == armPipePkg::resetPc && !cpuValid) ##1 !cpuValid)
    else begin
        $error("core did not leave reset in its reset state");
        failCount++;
    end

endmodule

`default_nettype wire

/* armCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module armCoreTb;

    localparam int romWords = 64;
    localparam int dataWords = 64;
    localparam int recordWords = 192;
    localparam int resetTimeout = 20;
    localparam int storeTimeout = 2000;
    localparam int loopTimeout = 40;
    // B . in any slot
    localparam armPipePkg::wordT selfLoop = 32'hEAFF_FFFE;

    wire CLK;
    wire Reset;
    armPipePkg::wordT instr;
    armPipePkg::wordT romIndex;
    armPipePkg::wordT readData = '0;
    logic cacheReady = 1'b0;
    armPipePkg::wordT pc;
    armPipePkg::wordT aluResult;
    armPipePkg::wordT writeData;
    logic cpuValid;
    logic cpuOp;

    armPipePkg::wordT rom [0:romWords-1];
    armPipePkg::wordT dataMem [0:dataWords-1];
    armPipePkg::wordT testData [0:recordWords-1];
    armPipePkg::wordT expAddr [$];
    armPipePkg::wordT expData [$];
    armPipePkg::wordT endPc = '0;
    logic busy = 1'b0;
    int waitLeft = 0;
    int storeCount = 0;

    tbClock clockGen (.CLK(CLK), .Reset(Reset));

    armCore dut (
        .CLK(CLK), .Reset(Reset), .instr(instr), .readData(readData),
        .cacheReady(cacheReady), .pc(pc), .aluResult(aluResult),
        .writeData(writeData), .cpuValid(cpuValid), .cpuOp(cpuOp)
    );

    bind armCore armCoreChk chk (
        .CLK(CLK), .Reset(Reset), .pc(pc), .aluResult(aluResult),
        .writeData(writeData), .cpuValid(cpuValid), .cpuOp(cpuOp),
        .cacheReady(cacheReady)
    );

    // combinational instruction port
    assign romIndex = pc / armPipePkg::pcStep;
    assign instr = (romIndex < romWords) ? rom[romIndex] : selfLoop;

    task automatic stopWithFail();
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic failWith(input string why);
        $display("%s (time %0t)", why, $time);
        stopWithFail();
    endtask

    task automatic checkStore(input armPipePkg::wordT addr, input armPipePkg::wordT data);
        armPipePkg::wordT wantAddr;
        armPipePkg::wordT wantData;
        if (expAddr.size() == 0) begin
            failWith($sformatf("unexpected store of 0x%08h to 0x%08h", data, addr));
        end else begin
            wantAddr = expAddr.pop_front();
            wantData = expData.pop_front();
            if (addr !== wantAddr || data !== wantData) begin
                $display({"** Error at %0t: store %0d wrote 0x%08h to 0x%08h,",
                    " expected 0x%08h to 0x%08h"},
                    $time, storeCount, data, addr, wantData, wantAddr);
                stopWithFail();
            end
            storeCount++;
        end
    endtask

    task automatic checkEndPc(input armPipePkg::wordT actual, input armPipePkg::wordT expected);
        if (actual !== expected) begin
            $display("** Error at %0t: self-loop pc 0x%08h, expected 0x%08h",
                $time, actual, expected);
            stopWithFail();
        end
    endtask

    task automatic loadTestData();
        int i;
        logic done;
        armPipePkg::wordT tag;
        for (i = 0; i < romWords; i++) begin
            rom[i] = selfLoop;
        end
        // untouched words carry their own byte address
        for (i = 0; i < dataWords; i++) begin
            dataMem[i] = {16'hd00d, 16'(i * 4)};
        end
        for (i = 0; i < recordWords; i++) begin
            testData[i] = '0;
        end
        $readmemh("armCoreTestdata.hex", testData);
        i = 0;
        done = 1'b0;
        while (!done && i + 2 < recordWords) begin
            tag = testData[i];
            case (tag)
                32'd0: done = 1'b1;
                32'd1: rom[testData[i+1] / armPipePkg::pcStep] = testData[i+2];
                32'd2: dataMem[testData[i+1] / armPipePkg::pcStep] = testData[i+2];
                32'd3: begin
                    expAddr.push_back(testData[i+1]);
                    expData.push_back(testData[i+2]);
                end
                32'd4: endPc = testData[i+1];
                default: failWith($sformatf("unknown record tag %0h in test data", tag));
            endcase
            i += 3;
        end
        if (expAddr.size() == 0) begin
            failWith("test data holds no expected stores");
        end
    endtask

    task automatic serveAccess();
        if (aluResult >= dataWords * 4 || aluResult[1:0] != 2'b00) begin
            failWith($sformatf("data access to 0x%08h is outside the memory model", aluResult));
        end else if (cpuOp) begin
            readData = dataMem[aluResult / armPipePkg::pcStep];
        end else begin
            dataMem[aluResult / armPipePkg::pcStep] = writeData;
            checkStore(aluResult, writeData);
        end
        cacheReady = 1'b1;
    endtask

    // data memory, zero to three wait cycles per access
    initial begin
        void'($urandom(32'h4c782c13));
        forever begin
            @(negedge CLK);
            if (Reset !== 1'b0) begin
                cacheReady = 1'b0;
                busy = 1'b0;
            end else begin
                // ready was seen at the last rising edge, so that access is done
                if (cacheReady) begin
                    cacheReady = 1'b0;
                    busy = 1'b0;
                end
                if (cpuValid && !busy) begin
                    busy = 1'b1;
                    waitLeft = $urandom % 4;
                end
                if (busy) begin
                    if (waitLeft == 0) begin
                        serveAccess();
                    end else begin
                        waitLeft--;
                    end
                end
            end
        end
    end

    always @(negedge CLK) begin
        if (dut.chk.failCount != 0) begin
            failWith("a bound assertion on the core fired");
        end
    end

    initial begin
        int cycles;
        armPipePkg::wordT lastPc;
        logic jumped;
        loadTestData();

        cycles = 0;
        while (Reset !== 1'b0) begin
            @(negedge CLK);
            cycles++;
            if (cycles > resetTimeout) begin
                failWith("reset was never released");
            end
        end

        // memory model checks each store as it is served
        cycles = 0;
        while (expAddr.size() != 0) begin
            @(posedge CLK);
            cycles++;
            if (cycles > storeTimeout) begin
                failWith($sformatf("timeout with %0d stores still expected", expAddr.size()));
            end
        end

        // next redirect lands on the self-loop
        @(negedge CLK);
        lastPc = pc;
        jumped = 1'b0;
        cycles = 0;
        while (!jumped) begin
            @(negedge CLK);
            cycles++;
            if (pc != lastPc && pc != lastPc + armPipePkg::pcStep) begin
                jumped = 1'b1;
            end else begin
                lastPc = pc;
            end
            if (!jumped && cycles > loopTimeout) begin
                failWith("pc never branched back into the self-loop");
            end
        end
        checkEndPc(pc, endPc);

        if (dut.chk.failCount != 0) begin
            failWith("a bound assertion on the core fired");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* armCoreTestdata.hex */
// tag address value: 1 program word, 2 initial data word, 3 expected store in order
// 4 final self-loop pc in the address column, 0 ends the records
1 00000000 e2000000
1 00000004 e2801005
1 00000008 e2812003
1 0000000c e0423001
1 00000010 e3834030
1 00000014 e0045001
1 00000018 e0856004
1 0000001c e5806040
1 00000020 e5803044
1 00000024 e5907080
1 00000028 e2878011
1 0000002c e5808048
1 00000030 e5909084
1 00000034 e580904c
1 00000038 e3510005
1 0000003c 05802050
1 00000040 15803054
1 00000044 e1530001
1 00000048 b5804058
1 0000004c a580505c
1 00000050 15801060
1 00000054 b280a007
1 00000058 a28aa001
1 0000005c e580a064
1 00000060 ea000001
1 00000064 e5801068
1 00000068 e580206c
1 0000006c e3500000
1 00000070 1a000000
1 00000074 e5808070
1 00000078 e5806074
1 0000007c eafffffe
2 00000080 00001000
2 00000084 cafef00d
3 00000040 00000034
3 00000044 00000003
3 00000048 00001011
3 0000004c cafef00d
3 00000050 00000008
3 00000058 00000033
3 00000060 00000005
3 00000064 00000007
3 00000070 00001011
3 00000074 00000034
4 0000007c 00000000
0 00000000 00000000

/* sim.f */
armIsaPkg.sv
armPipePkg.sv
armDecoder.sv
armRegFile.sv
armExecute.sv
armHazard.sv
armCore.sv
tbClock.sv
armCoreChk.sv
armCoreTb.sv

/* Bender.yml */
package:
  name: arm_core

sources:
  - armIsaPkg.sv
  - armPipePkg.sv
  - armDecoder.sv
  - armRegFile.sv
  - armExecute.sv
  - armHazard.sv
  - armCore.sv
  - target: test
    files:
      - tbClock.sv
      - armCoreChk.sv
      - armCoreTb.sv
